// File: src.f
+incdir+.
arith_pkg.sv
axil_pkg.sv
wallace_tree.sv
prefix_adder.sv
mult_axil_regs.sv
mult_axil.sv
mult_axil_sva.sv
mult_axil_tb.sv

// File: mult_axil_tb.sv
`include "mult_macros.svh"

module mult_axil_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 20;
	localparam int NUM_RANDOM = 200;
	localparam int NUM_STALLED = 20;
	localparam int NUM_OTHER = 40;
	localparam int STALL_MAX = 8;
	// About eight bus transfers per product, each four cycles plus a stall
	localparam int CYCLES_PER_OP = `MULT_LATENCY + 8 * (4 + STALL_MAX);
	localparam int TIMEOUT_NS = 2 * (NUM_RANDOM + NUM_STALLED + NUM_OTHER) *
		CYCLES_PER_OP * CLK_PERIOD;
	localparam logic [`DATA_W-1:0] OP_MASK = {{(`DATA_W-`OPERAND_W){1'b0}}, {`OPERAND_W{1'b1}}};

	logic clk;
	logic rst;
	logic [`ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [`DATA_W-1:0] wdata;
	logic [`DATA_W/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [`ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [`DATA_W-1:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	int stall_max = 0;
	logic [`DATA_W-1:0] cur_a;
	logic [`DATA_W-1:0] cur_b;
	arith_pkg::product_t last_prod;
	string name_q[$];
	logic [63:0] exp_q[$];
	logic [63:0] act_q[$];

	mult_axil i_mult_axil (
		.clk     (clk),
		.rst     (rst),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic arith_pkg::product_t ref_product(input arith_pkg::operand_t a,
		input arith_pkg::operand_t b);
		return arith_pkg::product_t'(a) * arith_pkg::product_t'(b);
	endfunction

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("STATUS: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic check(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (actual !== expected)
		begin
			$display("error %s expected %h actual %h", name, expected, actual);
			fail_run("value mismatch");
		end
	endtask

	task automatic expect_eq(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		name_q.push_back(name);
		exp_q.push_back(expected);
		act_q.push_back(actual);
	endtask

	// Comparer
	initial
	begin
		string name;
		logic [63:0] expected;
		logic [63:0] actual;
		forever
		begin
			wait (exp_q.size() != 0);
			name = name_q.pop_front();
			expected = exp_q.pop_front();
			actual = act_q.pop_front();
			check(name, expected, actual);
		end
	end

	task automatic axi_write(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data,
		output logic [1:0] resp);
		int hold;
		hold = (stall_max > 0) ? $urandom_range(stall_max) : 0;
		@(posedge clk);
		awaddr <= addr;
		wdata <= data;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		do
			@(posedge clk);
		while (!awready);
		// Address and data channels are accepted in the same cycle
		expect_eq("write wready with awready", 1'b1, wready);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		repeat (hold) @(posedge clk);
		bready <= 1'b1;
		do
			@(posedge clk);
		while (!bvalid);
		resp = bresp;
		bready <= 1'b0;
	endtask

	task automatic axi_read(input logic [`ADDR_W-1:0] addr, output logic [`DATA_W-1:0] data,
		output logic [1:0] resp);
		int hold;
		hold = (stall_max > 0) ? $urandom_range(stall_max) : 0;
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		do
			@(posedge clk);
		while (!arready);
		arvalid <= 1'b0;
		repeat (hold) @(posedge clk);
		rready <= 1'b1;
		do
			@(posedge clk);
		while (!rvalid);
		data = rdata;
		resp = rresp;
		rready <= 1'b0;
	endtask

	task automatic write_expect(input string name, input logic [`ADDR_W-1:0] addr,
		input logic [`DATA_W-1:0] data, input logic [1:0] exp_resp);
		logic [1:0] resp;
		axi_write(addr, data, resp);
		expect_eq({name, " bresp"}, exp_resp, resp);
	endtask

	// Response code and data compared as one value
	task automatic read_expect(input string name, input logic [`ADDR_W-1:0] addr,
		input logic [`DATA_W-1:0] exp_data, input logic [1:0] exp_resp);
		logic [`DATA_W-1:0] data;
		logic [1:0] resp;
		axi_read(addr, data, resp);
		expect_eq(name, {exp_resp, exp_data}, {resp, data});
	endtask

	task automatic set_operands(input logic [`DATA_W-1:0] a, input logic [`DATA_W-1:0] b);
		cur_a = a & OP_MASK;
		cur_b = b & OP_MASK;
		last_prod = ref_product(a[`OPERAND_W-1:0], b[`OPERAND_W-1:0]);
	endtask

	// Done set and nothing in flight
	task automatic wait_idle(input string name);
		logic [`DATA_W-1:0] status;
		logic [1:0] resp;
		do
		begin
			axi_read(axil_pkg::REG_STATUS, status, resp);
			expect_eq({name, " status rresp"}, axil_pkg::RESP_OKAY, resp);
		end
		while (status[1:0] != 2'b01);
	endtask

	task automatic check_result(input string name);
		read_expect({name, " res_lo"}, axil_pkg::REG_RES_LO, last_prod[`DATA_W-1:0],
			axil_pkg::RESP_OKAY);
		read_expect({name, " res_hi"}, axil_pkg::REG_RES_HI,
			`DATA_W'(last_prod[`PRODUCT_W-1:`DATA_W]), axil_pkg::RESP_OKAY);
	endtask

	task automatic run_product(input string name, input logic [`DATA_W-1:0] a,
		input logic [`DATA_W-1:0] b);
		write_expect({name, " write a"}, axil_pkg::REG_A, a, axil_pkg::RESP_OKAY);
		write_expect({name, " write b"}, axil_pkg::REG_B, b, axil_pkg::RESP_OKAY);
		set_operands(a, b);
		wait_idle(name);
		check_result(name);
		read_expect({name, " read a"}, axil_pkg::REG_A, cur_a, axil_pkg::RESP_OKAY);
	endtask

	initial
	begin
		#(TIMEOUT_NS);
		fail_run("timeout, the tests did not finish in time");
	end

	initial
	begin
		wait (i_mult_axil.i_regs.i_sva.fail_count != 0);
		fail_run("a bus handshake assertion failed");
	end

	initial
	begin
		logic [`DATA_W-1:0] a_val;
		logic [`DATA_W-1:0] b_val;
		logic [`DATA_W-1:0] status;
		logic [1:0] resp;
		logic [`ADDR_W-1:0] bad_addr [0:3];

		void'($urandom(32'h70dd));
		rst = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '1;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;

		read_expect("reset status", axil_pkg::REG_STATUS, '0, axil_pkg::RESP_OKAY);
		read_expect("reset res_lo", axil_pkg::REG_RES_LO, '0, axil_pkg::RESP_OKAY);
		read_expect("reset res_hi", axil_pkg::REG_RES_HI, '0, axil_pkg::RESP_OKAY);

		a_val = $urandom;
		run_product("zero times x", 0, a_val);
		run_product("x times zero", a_val, 0);
		run_product("one times x", 1, a_val);
		run_product("x times one", a_val, 1);
		run_product("max times max", OP_MASK, OP_MASK);
		for (int i = 0; i < `OPERAND_W; i++)
			run_product($sformatf("power %0d", i), 1 << i, 1 << ((i * 7) % `OPERAND_W));

		for (int i = 0; i < NUM_RANDOM; i++)
			run_product($sformatf("random %0d", i), $urandom, $urandom);

		// Second launch while the first is still in the tree
		for (int i = 0; i < 5; i++)
		begin
			a_val = $urandom;
			b_val = $urandom;
			write_expect("burst a", axil_pkg::REG_A, a_val, axil_pkg::RESP_OKAY);
			write_expect("burst b1", axil_pkg::REG_B, b_val, axil_pkg::RESP_OKAY);
			write_expect("burst b2", axil_pkg::REG_B, ~b_val, axil_pkg::RESP_OKAY);
			axi_read(axil_pkg::REG_STATUS, status, resp);
			expect_eq($sformatf("burst %0d busy", i), 1, status[1]);
			set_operands(a_val, ~b_val);
			wait_idle("burst");
			check_result($sformatf("burst %0d", i));
		end

		bad_addr[0] = 5'h14;
		bad_addr[1] = 5'h18;
		bad_addr[2] = 5'h1C;
		bad_addr[3] = 5'h06;
		for (int i = 0; i < 4; i++)
		begin
			write_expect($sformatf("unmapped write %0d", i), bad_addr[i], $urandom,
				axil_pkg::RESP_SLVERR);
			read_expect($sformatf("unmapped read %0d", i), bad_addr[i], '0,
				axil_pkg::RESP_SLVERR);
		end
		write_expect("write res_lo", axil_pkg::REG_RES_LO, $urandom, axil_pkg::RESP_OKAY);
		check_result("after ignored write");
		read_expect("operand a kept", axil_pkg::REG_A, cur_a, axil_pkg::RESP_OKAY);
		read_expect("operand b kept", axil_pkg::REG_B, cur_b, axil_pkg::RESP_OKAY);

		stall_max = STALL_MAX;
		for (int i = 0; i < NUM_STALLED; i++)
			run_product($sformatf("stalled %0d", i), $urandom, $urandom);
		stall_max = 0;

		wait (exp_q.size() == 0);
		@(posedge clk);
		if (i_mult_axil.i_regs.i_sva.fail_count != 0)
		begin
			fail_run("a bus handshake assertion failed");
		end
		else
		begin
			$display("STATUS: PASS");
			$finish;
		end
	end

endmodule

// File: mult_axil_sva.sv
`include "mult_macros.svh"

module mult_axil_sva (
	input logic               clk,
	input logic               rst,
	input logic               awready,
	input logic               wready,
	input logic [1:0]         bresp,
	input logic               bvalid,
	input logic               bready,
	input logic [`DATA_W-1:0] rdata,
	input logic [1:0]         rresp,
	input logic               rvalid,
	input logic               rready
);

	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// A pending write response holds until taken
	a_b_hold: assert property (@(posedge clk) disable iff (rst)
		bvalid && !bready |=> bvalid && $stable(bresp))
	else
	begin
		$error("bvalid dropped or bresp changed before bready");
		fail_count++;
	end

	a_r_hold: assert property (@(posedge clk) disable iff (rst)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
	else
	begin
		$error("rvalid dropped or read data changed before rready");
		fail_count++;
	end

	a_no_aw_during_b: assert property (@(posedge clk) disable iff (rst)
		bvalid |-> !awready && !wready)
	else
	begin
		$error("write accepted while bvalid is high");
		fail_count++;
	end

endmodule

bind mult_axil_regs mult_axil_sva i_sva (.*);

// File: mult_axil.sv
`include "mult_macros.svh"

module mult_axil (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [`ADDR_W-1:0]   awaddr,
	input  logic                 awvalid,
	output logic                 awready,
	input  logic [`DATA_W-1:0]   wdata,
	input  logic [`DATA_W/8-1:0] wstrb,
	input  logic                 wvalid,
	output logic                 wready,
	output logic [1:0]           bresp,
	output logic                 bvalid,
	input  logic                 bready,
	input  logic [`ADDR_W-1:0]   araddr,
	input  logic                 arvalid,
	output logic                 arready,
	output logic [`DATA_W-1:0]   rdata,
	output logic [1:0]           rresp,
	output logic                 rvalid,
	input  logic                 rready
);

	arith_pkg::operand_t op_a;
	arith_pkg::operand_t op_b;
	logic launch;
	arith_pkg::row_t sum_row;
	arith_pkg::row_t carry_row;
	logic row_valid;
	arith_pkg::product_t adder_sum;
	arith_pkg::product_t product;
	logic product_valid;

	mult_axil_regs i_regs (
		.clk           (clk),
		.rst           (rst),
		.awaddr        (awaddr),
		.awvalid       (awvalid),
		.awready       (awready),
		.wdata         (wdata),
		.wstrb         (wstrb),
		.wvalid        (wvalid),
		.wready        (wready),
		.bresp         (bresp),
		.bvalid        (bvalid),
		.bready        (bready),
		.araddr        (araddr),
		.arvalid       (arvalid),
		.arready       (arready),
		.rdata         (rdata),
		.rresp         (rresp),
		.rvalid        (rvalid),
		.rready        (rready),
		.product       (product),
		.product_valid (product_valid),
		.op_a          (op_a),
		.op_b          (op_b),
		.launch        (launch)
	);

	wallace_tree i_tree (
		.clk       (clk),
		.rst       (rst),
		.op_a      (op_a),
		.op_b      (op_b),
		.launch    (launch),
		.sum_row   (sum_row),
		.carry_row (carry_row),
		.row_valid (row_valid)
	);

	prefix_adder #(
		.WIDTH (`PRODUCT_W)
	) i_adder (
		.a   (sum_row),
		.b   (carry_row),
		.sum (adder_sum)
	);

	// Fifth pipeline stage
	always_ff @(posedge clk)
	begin
		product <= adder_sum;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			product_valid <= 1'b0;
		else
			product_valid <= row_valid;
	end

endmodule

// File: mult_axil_regs.sv
`include "mult_macros.svh"

module mult_axil_regs (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [`ADDR_W-1:0]   awaddr,
	input  logic                 awvalid,
	output logic                 awready,
	input  logic [`DATA_W-1:0]   wdata,
	input  logic [`DATA_W/8-1:0] wstrb,
	input  logic                 wvalid,
	output logic                 wready,
	output logic [1:0]           bresp,
	output logic                 bvalid,
	input  logic                 bready,
	input  logic [`ADDR_W-1:0]   araddr,
	input  logic                 arvalid,
	output logic                 arready,
	output logic [`DATA_W-1:0]   rdata,
	output logic [1:0]           rresp,
	output logic                 rvalid,
	input  logic                 rready,
	input  arith_pkg::product_t  product,
	input  logic                 product_valid,
	output arith_pkg::operand_t  op_a,
	output arith_pkg::operand_t  op_b,
	output logic                 launch
);

	localparam int CNT_W = $clog2(`MULT_LATENCY + 1);

	axil_pkg::chan_state_e wr_state;
	axil_pkg::chan_state_e rd_state;
	arith_pkg::product_t result_q;
	logic done;
	logic busy;
	logic [CNT_W-1:0] in_flight;
	logic wr_fire;
	logic rd_fire;

	// Address and data are taken together in one cycle
	assign wr_fire = (wr_state == axil_pkg::CH_IDLE) && awvalid && wvalid;
	assign awready = wr_fire;
	assign wready = wr_fire;
	assign bvalid = (wr_state == axil_pkg::CH_RESP);

	assign rd_fire = (rd_state == axil_pkg::CH_IDLE) && arvalid;
	assign arready = rd_fire;
	assign rvalid = (rd_state == axil_pkg::CH_RESP);

	assign busy = (in_flight != '0);

	always_ff @(posedge clk)
	begin
		if (rst)
			wr_state <= axil_pkg::CH_IDLE;
		else if (wr_fire)
			wr_state <= axil_pkg::CH_RESP;
		else if (bvalid && bready)
			wr_state <= axil_pkg::CH_IDLE;
	end

	always_ff @(posedge clk)
	begin
		if (wr_fire)
		begin
			bresp <= axil_pkg::RESP_OKAY;
			case (awaddr)
				axil_pkg::REG_A: op_a <= wdata[`OPERAND_W-1:0];
				axil_pkg::REG_B: op_b <= wdata[`OPERAND_W-1:0];
				// Read-only registers
				axil_pkg::REG_RES_LO, axil_pkg::REG_RES_HI, axil_pkg::REG_STATUS: ;
				default: bresp <= axil_pkg::RESP_SLVERR;
			endcase
		end
	end

	// Operands are stable in the cycle after the B write
	always_ff @(posedge clk)
	begin
		if (rst)
			launch <= 1'b0;
		else
			launch <= wr_fire && (awaddr == axil_pkg::REG_B);
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			result_q <= '0;
			done <= 1'b0;
			in_flight <= '0;
		end
		else
		begin
			if (product_valid)
				result_q <= product;
			// A new launch makes the held result stale
			if (launch)
				done <= 1'b0;
			else if (product_valid)
				done <= 1'b1;
			in_flight <= in_flight + CNT_W'(launch) - CNT_W'(product_valid);
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			rd_state <= axil_pkg::CH_IDLE;
		else if (rd_fire)
			rd_state <= axil_pkg::CH_RESP;
		else if (rvalid && rready)
			rd_state <= axil_pkg::CH_IDLE;
	end

	always_ff @(posedge clk)
	begin
		if (rd_fire)
		begin
			rresp <= axil_pkg::RESP_OKAY;
			case (araddr)
				axil_pkg::REG_A: rdata <= `DATA_W'(op_a);
				axil_pkg::REG_B: rdata <= `DATA_W'(op_b);
				axil_pkg::REG_RES_LO: rdata <= result_q[`DATA_W-1:0];
				axil_pkg::REG_RES_HI: rdata <= `DATA_W'(result_q[`PRODUCT_W-1:`DATA_W]);
				axil_pkg::REG_STATUS: rdata <= `DATA_W'({busy, done});
				default:
				begin
					rdata <= '0;
					rresp <= axil_pkg::RESP_SLVERR;
				end
			endcase
		end
	end

endmodule

// File: prefix_adder.sv
`include "mult_macros.svh"

module prefix_adder #(
	parameter int WIDTH = `PRODUCT_W
) (
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	output logic [WIDTH-1:0] sum
);

	localparam int LEVELS = $clog2(WIDTH);

	wire [WIDTH-1:0] gen [0:LEVELS];
	// Group propagate is not needed after the last level
	wire [WIDTH-1:0] prop [0:LEVELS-1];

	assign gen[0] = a & b;
	assign prop[0] = a ^ b;

	// Kogge-Stone, span doubles each level
	for (genvar lv = 0; lv < LEVELS; lv++)
	begin : g_level
		localparam int DIST = 1 << lv;

		for (genvar i = 0; i < WIDTH; i++)
		begin : g_bit
			if (i >= DIST)
			begin : g_op
				assign gen[lv+1][i] = gen[lv][i] | (prop[lv][i] & gen[lv][i-DIST]);
				if (lv + 1 < LEVELS)
				begin : g_prop
					assign prop[lv+1][i] = prop[lv][i] & prop[lv][i-DIST];
				end
			end
			else
			begin : g_keep
				assign gen[lv+1][i] = gen[lv][i];
				if (lv + 1 < LEVELS)
				begin : g_prop
					assign prop[lv+1][i] = prop[lv][i];
				end
			end
		end
	end

	// Carry into bit i is the group generate of bits i-1 down to 0
	// gen[LEVELS][WIDTH-1] is the carry out and is dropped
	assign sum = prop[0] ^ {gen[LEVELS][WIDTH-2:0], 1'b0};

endmodule

// File: wallace_tree.sv
`include "mult_macros.svh"

module wallace_tree (
	input  logic                clk,
	input  logic                rst,
	input  arith_pkg::operand_t op_a,
	input  arith_pkg::operand_t op_b,
	input  logic                launch,
	output arith_pkg::row_t     sum_row,
	output arith_pkg::row_t     carry_row,
	output logic                row_valid
);

	localparam int ROWS = `OPERAND_W;
	// Two layers per register, the last stage holds a single layer
	localparam int LAYERS = 2 * `REDUCE_STAGES - 1;

	// Rows left after a number of 3:2 layers, 20 14 10 7 5 4 3 2
	function automatic int rows_at(input int layer);
		int n;
		n = ROWS;
		for (int i = 0; i < layer; i++)
			n = n - n / 3;
		return n;
	endfunction

	wire arith_pkg::row_t pp [0:ROWS-1];
	wire arith_pkg::row_t lyr_in [0:LAYERS-1][0:ROWS-1];
	wire arith_pkg::row_t lyr_out [0:LAYERS-1][0:ROWS-1];
	arith_pkg::row_t stage_q [0:`REDUCE_STAGES-1][0:ROWS-1];
	logic [`REDUCE_STAGES-1:0] vld_q;

	// AND array, row r weighted by 2**r
	for (genvar r = 0; r < ROWS; r++)
	begin : g_pp
		assign pp[r] = arith_pkg::row_t'(op_a & {ROWS{op_b[r]}}) << r;
	end

	for (genvar l = 0; l < LAYERS; l++)
	begin : g_layer
		localparam int N_IN = rows_at(l);
		localparam int N_GRP = N_IN / 3;
		localparam int N_OUT = N_IN - N_GRP;

		for (genvar r = 0; r < ROWS; r++)
		begin : g_row
			// Even layers start from a stage register
			if (l == 0)
			begin : g_src_pp
				assign lyr_in[l][r] = pp[r];
			end
			else if (l % 2 == 1)
			begin : g_src_comb
				assign lyr_in[l][r] = lyr_out[l-1][r];
			end
			else
			begin : g_src_reg
				assign lyr_in[l][r] = stage_q[l/2-1][r];
			end

			if (r < 2 * N_GRP)
			begin : g_fa
				localparam int B = 3 * (r / 2);
				if (r % 2 == 0)
				begin : g_sum
					assign lyr_out[l][r] = lyr_in[l][B] ^ lyr_in[l][B+1] ^ lyr_in[l][B+2];
				end
				else
				begin : g_carry
					// Carry moves one column up, bit 39 falls off
					assign lyr_out[l][r] = ((lyr_in[l][B] & lyr_in[l][B+1]) |
						(lyr_in[l][B+1] & lyr_in[l][B+2]) |
						(lyr_in[l][B] & lyr_in[l][B+2])) << 1;
				end
			end
			else if (r < N_OUT)
			begin : g_pass
				// Leftover rows skip this layer
				assign lyr_out[l][r] = lyr_in[l][r + N_GRP];
			end
			else
			begin : g_unused
				assign lyr_out[l][r] = '0;
			end
		end
	end

	for (genvar s = 0; s < `REDUCE_STAGES; s++)
	begin : g_stage
		localparam int SRC = (2 * s + 1 < LAYERS) ? 2 * s + 1 : LAYERS - 1;

		always_ff @(posedge clk)
		begin
			for (int r = 0; r < ROWS; r++)
				stage_q[s][r] <= lyr_out[SRC][r];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			vld_q <= '0;
		else
			vld_q <= {vld_q[`REDUCE_STAGES-2:0], launch};
	end

	assign sum_row = stage_q[`REDUCE_STAGES-1][0];
	assign carry_row = stage_q[`REDUCE_STAGES-1][1];
	assign row_valid = vld_q[`REDUCE_STAGES-1];

endmodule

// File: axil_pkg.sv
`include "mult_macros.svh"

package axil_pkg;

	// Register map, byte offsets
	typedef enum logic [`ADDR_W-1:0] {
		REG_A      = 5'h00,
		REG_B      = 5'h04,
		REG_RES_LO = 5'h08,
		REG_RES_HI = 5'h0C,
		REG_STATUS = 5'h10
	} reg_addr_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} resp_e;

	// Shared by the write and the read channel
	typedef enum logic {
		CH_IDLE = 1'b0,
		CH_RESP = 1'b1
	} chan_state_e;

endpackage

// File: arith_pkg.sv
`include "mult_macros.svh"

package arith_pkg;

	// Unsigned multiplier operand
	typedef logic [`OPERAND_W-1:0] operand_t;

	// Full-width product
	typedef logic [`PRODUCT_W-1:0] product_t;

	// One partial-product or carry-save row, aligned to product bit 0
	typedef logic [`PRODUCT_W-1:0] row_t;

endpackage

// File: mult_macros.svh
`ifndef MULT_MACROS_SVH
`define MULT_MACROS_SVH

// Datapath widths
`define OPERAND_W 20
`define PRODUCT_W 40

// Registered carry-save stages in the tree
`define REDUCE_STAGES 4

// AXI4-Lite bus widths
`define ADDR_W 5
`define DATA_W 32

// Launch to product_valid, tree stages plus output register
`define MULT_LATENCY 5

`endif
